// File: src/pad_pkg.sv
/*
 * Shared constants, word types and AXI channel structs
 * for the mirror-padding DMA engine
 */
`default_nettype none

package pad_pkg;

    localparam int TILE       = 4;  // Tile edge in words
    localparam int BUF_DIM    = 6;  // Tile plus one pad word each side
    localparam int BEAT_BYTES = 4;
    localparam int BUS_ADDR_W = 32; // Address width on the bus

    typedef logic [31:0] data_t;
    typedef logic [5:0]  dim_t;     // Width, tile coordinate or row index
    typedef logic [3:0]  len_t;     // AXI burst length minus one

    // Current tile and which matrix edges it touches
    typedef struct packed {
        dim_t bx;
        dim_t by;
        logic is_top;
        logic is_bottom;
        logic is_left;
        logic is_right;
    } tile_pos_t;

    typedef struct packed {
        logic [BUS_ADDR_W-1:0] addr;
        len_t                  len;
    } rd_req_t;

    typedef struct packed {
        logic [BUS_ADDR_W-1:0] addr;
        len_t                  len;
    } wr_req_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } wr_beat_t;

endpackage

`default_nettype wire

// File: src/pad_tile_walker.sv
/*
 * Row-major tile coordinate counter with edge flags
 */
`default_nettype none

module pad_tile_walker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                init_i,
    input  pad_pkg::dim_t       mat_width_i,
    input  logic                next_tile_i,
    output pad_pkg::tile_pos_t  pos_o,
    output logic                last_tile_o
);

    pad_pkg::dim_t bx_q;
    pad_pkg::dim_t by_q;
    pad_pkg::dim_t tiles_q;   // Tiles per row and per column
    logic          row_end;

    assign row_end = (bx_q == tiles_q - 6'd1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bx_q    <= '0;
            by_q    <= '0;
            tiles_q <= '0;
        end else if (init_i) begin
            bx_q    <= '0;
            by_q    <= '0;
            tiles_q <= mat_width_i >> 2;  // N / 4
        end else if (next_tile_i) begin
            if (row_end) begin
                bx_q <= '0;
                by_q <= by_q + 6'd1;
            end else begin
                bx_q <= bx_q + 6'd1;
            end
        end
    end

    assign pos_o.bx        = bx_q;
    assign pos_o.by        = by_q;
    assign pos_o.is_top    = (by_q == '0);
    assign pos_o.is_bottom = (by_q == tiles_q - 6'd1);
    assign pos_o.is_left   = (bx_q == '0);
    assign pos_o.is_right  = row_end;

    // Bottom right tile closes the run
    assign last_tile_o = pos_o.is_bottom & row_end;

endmodule

`default_nettype wire

// File: src/pad_addr_gen.sv
/*
 * Read and write burst addresses for the current tile,
 * output burst length and number of output rows
 */
`default_nettype none

module pad_addr_gen #(
    parameter int ADDR_W = 32
) (
    input  logic [31:0]         src_base_i,
    input  logic [31:0]         dst_base_i,
    input  pad_pkg::dim_t       mat_width_i,
    input  pad_pkg::tile_pos_t  pos_i,
    input  logic [1:0]          rd_row_i,     // Local input row
    input  pad_pkg::dim_t       wr_row_i,     // Local output row
    output logic [31:0]         rd_addr_o,
    output logic [31:0]         wr_addr_o,
    output pad_pkg::len_t       wr_len_o,
    output logic [2:0]          wr_rows_o
);

    localparam logic [ADDR_W-1:0] TILE_A = ADDR_W'(pad_pkg::TILE);
    localparam logic [ADDR_W-1:0] BEAT_A = ADDR_W'(pad_pkg::BEAT_BYTES);

    logic [ADDR_W-1:0] n_w;
    logic [ADDR_W-1:0] out_w;      // Output row pitch N+2
    logic [ADDR_W-1:0] src_row;
    logic [ADDR_W-1:0] src_col;
    logic [ADDR_W-1:0] dst_row;
    logic [ADDR_W-1:0] dst_col;
    logic [ADDR_W-1:0] rd_sum;
    logic [ADDR_W-1:0] wr_sum;

    always_comb begin
        n_w     = ADDR_W'(mat_width_i);
        out_w   = n_w + ADDR_W'(2);
        src_row = ADDR_W'(pos_i.by) * TILE_A + ADDR_W'(rd_row_i);
        src_col = ADDR_W'(pos_i.bx) * TILE_A;

        // Edge tiles also own the pad row or column
        dst_row = pos_i.is_top  ? '0 : ADDR_W'(pos_i.by) * TILE_A + ADDR_W'(1);
        dst_col = pos_i.is_left ? '0 : ADDR_W'(pos_i.bx) * TILE_A + ADDR_W'(1);

        rd_sum = ADDR_W'(src_base_i) + (src_row * n_w + src_col) * BEAT_A;
        wr_sum = ADDR_W'(dst_base_i)
               + ((dst_row + ADDR_W'(wr_row_i)) * out_w + dst_col) * BEAT_A;
    end

    assign rd_addr_o = 32'(rd_sum);
    assign wr_addr_o = 32'(wr_sum);

    // 4 to 6 columns and rows
    assign wr_len_o  = pad_pkg::len_t'(pad_pkg::TILE - 1)
                     + pad_pkg::len_t'(pos_i.is_left)
                     + pad_pkg::len_t'(pos_i.is_right);
    assign wr_rows_o = 3'(pad_pkg::TILE) + 3'(pos_i.is_top) + 3'(pos_i.is_bottom);

endmodule

`default_nettype wire

// File: src/pad_tile_buffer.sv
/*
 * 6x6 tile buffer, 4x4 input in the centre,
 * one-cycle mirror fill of the pad ring, async row readout
 */
`default_nettype none

module pad_tile_buffer (
    input  logic            clk,
    input  logic            wr_en_i,
    input  logic [1:0]      wr_row_i,
    input  logic [1:0]      wr_col_i,
    input  pad_pkg::data_t  wr_data_i,
    input  logic            fill_i,
    input  logic [2:0]      rd_row_i,
    input  logic [2:0]      rd_col_i,
    output pad_pkg::data_t  rd_data_o
);

    localparam int LAST = pad_pkg::BUF_DIM - 1;

    pad_pkg::data_t mem [pad_pkg::BUF_DIM][pad_pkg::BUF_DIM];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_row_i + 3'd1][wr_col_i + 3'd1] <= wr_data_i;  // Centre offset
        end
        if (fill_i) begin
            for (int i = 1; i < LAST; i++) begin
                mem[0][i]    <= mem[2][i];       // m(-1) = 1
                mem[LAST][i] <= mem[LAST-2][i];  // m(N) = N-2
                mem[i][0]    <= mem[i][2];
                mem[i][LAST] <= mem[i][LAST-2];
            end
            // Corners take the diagonal neighbour
            mem[0][0]       <= mem[2][2];
            mem[0][LAST]    <= mem[2][LAST-2];
            mem[LAST][0]    <= mem[LAST-2][2];
            mem[LAST][LAST] <= mem[LAST-2][LAST-2];
        end
    end

    assign rd_data_o = mem[rd_row_i][rd_col_i];

endmodule

`default_nettype wire

// File: src/pad_dma_ctrl.sv
/*
 * DMA sequencer: per tile four AXI read bursts, buffer fill,
 * then one AXI write burst per owned output row
 */
`default_nettype none

module pad_dma_ctrl #(
    parameter int ADDR_W = 32
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic [31:0]         src_addr_i,
    input  logic [31:0]         dst_addr_i,
    input  pad_pkg::dim_t       mat_width_i,
    input  logic                start_i,
    output logic                done_o,
    output logic [31:0]         src_base_o,   // Latched configuration
    output logic [31:0]         dst_base_o,
    output pad_pkg::dim_t       mat_width_o,

    input  pad_pkg::tile_pos_t  pos_i,
    input  logic                last_tile_i,
    output logic                init_o,
    output logic                next_tile_o,

    input  logic [31:0]         rd_addr_i,
    input  logic [31:0]         wr_addr_i,
    input  pad_pkg::len_t       wr_len_i,
    input  logic [2:0]          wr_rows_i,
    output logic [1:0]          rd_row_o,
    output pad_pkg::dim_t       wr_row_o,

    output logic                buf_wr_en_o,
    output logic [1:0]          buf_wr_row_o,
    output logic [1:0]          buf_wr_col_o,
    output logic                buf_fill_o,
    output logic [2:0]          buf_rd_row_o,
    output logic [2:0]          buf_rd_col_o,
    input  pad_pkg::data_t      buf_data_i,

    output pad_pkg::rd_req_t    ar_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    input  logic                rlast_i,
    input  logic                rvalid_i,
    output logic                rready_o,
    output pad_pkg::wr_req_t    aw_o,
    output logic                awvalid_o,
    input  logic                awready_i,
    output pad_pkg::wr_beat_t   w_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    output logic                bready_o
);

    typedef enum logic [2:0] {
        S_IDLE, S_RD_ADDR, S_RD_DATA, S_FILL, S_WR_ADDR, S_WR_DATA, S_WR_RESP
    } state_t;

    state_t            state;
    logic [ADDR_W-1:0] src_q;
    logic [ADDR_W-1:0] dst_q;
    pad_pkg::dim_t     width_q;
    logic [1:0]        rd_row_q;
    logic [1:0]        rd_col_q;
    logic [2:0]        wr_row_q;
    pad_pkg::len_t     beat_q;
    logic              ar_hs;
    logic              r_hs;
    logic              aw_hs;
    logic              w_hs;
    logic              b_hs;
    logic              rows_done;

    assign ar_hs     = arvalid_o & arready_i;
    assign r_hs      = rvalid_i & rready_o;
    assign aw_hs     = awvalid_o & awready_i;
    assign w_hs      = wvalid_o & wready_i;
    assign b_hs      = bvalid_i & (state == S_WR_RESP);  // B only after last W
    assign rows_done = (wr_row_q == wr_rows_i - 3'd1);

    always_ff @(posedge clk) begin
        if (done_o && start_i) begin
            src_q   <= ADDR_W'(src_addr_i);
            dst_q   <= ADDR_W'(dst_addr_i);
            width_q <= mat_width_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            rd_row_q <= '0;
            rd_col_q <= '0;
            wr_row_q <= '0;
            beat_q   <= '0;
        end else begin
            case (state)
                S_IDLE: if (start_i) begin
                    rd_row_q <= '0;
                    rd_col_q <= '0;
                    state    <= S_RD_ADDR;
                end
                S_RD_ADDR: if (ar_hs) state <= S_RD_DATA;
                S_RD_DATA: if (r_hs) begin
                    rd_col_q <= rd_col_q + 2'd1;
                    if (rlast_i) begin
                        rd_col_q <= '0;
                        rd_row_q <= rd_row_q + 2'd1;  // Wraps to 0 after row 3
                        state    <= (rd_row_q == 2'd3) ? S_FILL : S_RD_ADDR;
                    end
                end
                S_FILL: begin
                    wr_row_q <= '0;
                    state    <= S_WR_ADDR;
                end
                S_WR_ADDR: if (aw_hs) begin
                    beat_q <= '0;
                    state  <= S_WR_DATA;
                end
                S_WR_DATA: if (w_hs) begin
                    beat_q <= beat_q + 4'd1;
                    if (w_o.last) state <= S_WR_RESP;
                end
                S_WR_RESP: if (b_hs) begin
                    if (!rows_done) begin
                        wr_row_q <= wr_row_q + 3'd1;
                        state    <= S_WR_ADDR;
                    end else begin
                        state <= last_tile_i ? S_IDLE : S_RD_ADDR;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign done_o      = (state == S_IDLE);
    assign init_o      = done_o & start_i;
    assign next_tile_o = b_hs & rows_done & ~last_tile_i;
    assign src_base_o  = 32'(src_q);
    assign dst_base_o  = 32'(dst_q);
    assign mat_width_o = width_q;
    assign rd_row_o    = rd_row_q;
    assign wr_row_o    = pad_pkg::dim_t'(wr_row_q);

    // R beats land straight in the buffer
    assign buf_wr_en_o  = r_hs;
    assign buf_wr_row_o = rd_row_q;
    assign buf_wr_col_o = rd_col_q;
    assign buf_fill_o   = (state == S_FILL);

    // Skip the pad ring on sides that are not matrix edges
    assign buf_rd_row_o = (pos_i.is_top ? 3'd0 : 3'd1) + wr_row_q;
    assign buf_rd_col_o = (pos_i.is_left ? 3'd0 : 3'd1) + 3'(beat_q);

    assign ar_o.addr = rd_addr_i;
    assign ar_o.len  = pad_pkg::len_t'(pad_pkg::TILE - 1);
    assign arvalid_o = (state == S_RD_ADDR);
    assign rready_o  = (state == S_RD_DATA);
    assign aw_o.addr = wr_addr_i;
    assign aw_o.len  = wr_len_i;
    assign awvalid_o = (state == S_WR_ADDR);
    assign w_o.data  = buf_data_i;
    assign w_o.last  = (beat_q == wr_len_i);
    assign wvalid_o  = (state == S_WR_DATA);
    assign bready_o  = (state == S_WR_DATA) | (state == S_WR_RESP);

endmodule

`default_nettype wire

// File: src/pad_dma_top.sv
/*
 * Mirror-padding DMA top: tile walker, address generator,
 * tile buffer and AXI controller
 */
`default_nettype none

module pad_dma_top #(
    parameter int ADDR_W = 32
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic [31:0]         src_addr_i,
    input  logic [31:0]         dst_addr_i,
    input  pad_pkg::dim_t       mat_width_i,
    input  logic                start_i,
    output logic                done_o,

    output pad_pkg::rd_req_t    ar_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    input  pad_pkg::data_t      rdata_i,
    input  logic                rlast_i,
    input  logic                rvalid_i,
    output logic                rready_o,

    output pad_pkg::wr_req_t    aw_o,
    output logic                awvalid_o,
    input  logic                awready_i,
    output pad_pkg::wr_beat_t   w_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    output logic                bready_o
);

    pad_pkg::tile_pos_t pos;
    logic               last_tile;
    logic               init;
    logic               next_tile;
    logic [31:0]        src_base;
    logic [31:0]        dst_base;
    pad_pkg::dim_t      cfg_width;
    logic [31:0]        rd_addr;
    logic [31:0]        wr_addr;
    pad_pkg::len_t      wr_len;
    logic [2:0]         wr_rows;
    logic [1:0]         rd_row;
    pad_pkg::dim_t      wr_row;
    logic               buf_wr_en;
    logic [1:0]         buf_wr_row;
    logic [1:0]         buf_wr_col;
    logic               buf_fill;
    logic [2:0]         buf_rd_row;
    logic [2:0]         buf_rd_col;
    pad_pkg::data_t     buf_data;

    pad_tile_walker u_walker (
        .clk         (clk),
        .rst_n       (rst_n),
        .init_i      (init),
        .mat_width_i (mat_width_i),  // Sampled on init, same edge as ctrl latch
        .next_tile_i (next_tile),
        .pos_o       (pos),
        .last_tile_o (last_tile)
    );

    pad_addr_gen #(.ADDR_W(ADDR_W)) u_addr (
        .src_base_i  (src_base),
        .dst_base_i  (dst_base),
        .mat_width_i (cfg_width),
        .pos_i       (pos),
        .rd_row_i    (rd_row),
        .wr_row_i    (wr_row),
        .rd_addr_o   (rd_addr),
        .wr_addr_o   (wr_addr),
        .wr_len_o    (wr_len),
        .wr_rows_o   (wr_rows)
    );

    pad_tile_buffer u_buf (
        .clk       (clk),
        .wr_en_i   (buf_wr_en),
        .wr_row_i  (buf_wr_row),
        .wr_col_i  (buf_wr_col),
        .wr_data_i (rdata_i),
        .fill_i    (buf_fill),
        .rd_row_i  (buf_rd_row),
        .rd_col_i  (buf_rd_col),
        .rd_data_o (buf_data)
    );

    pad_dma_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .src_addr_i   (src_addr_i),
        .dst_addr_i   (dst_addr_i),
        .mat_width_i  (mat_width_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .src_base_o   (src_base),
        .dst_base_o   (dst_base),
        .mat_width_o  (cfg_width),
        .pos_i        (pos),
        .last_tile_i  (last_tile),
        .init_o       (init),
        .next_tile_o  (next_tile),
        .rd_addr_i    (rd_addr),
        .wr_addr_i    (wr_addr),
        .wr_len_i     (wr_len),
        .wr_rows_i    (wr_rows),
        .rd_row_o     (rd_row),
        .wr_row_o     (wr_row),
        .buf_wr_en_o  (buf_wr_en),
        .buf_wr_row_o (buf_wr_row),
        .buf_wr_col_o (buf_wr_col),
        .buf_fill_o   (buf_fill),
        .buf_rd_row_o (buf_rd_row),
        .buf_rd_col_o (buf_rd_col),
        .buf_data_i   (buf_data),
        .ar_o         (ar_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .rlast_i      (rlast_i),
        .rvalid_i     (rvalid_i),
        .rready_o     (rready_o),
        .aw_o         (aw_o),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .w_o          (w_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i),
        .bvalid_i     (bvalid_i),
        .bready_o     (bready_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_axi_mem.sv
/*
 * AXI slave word memory for the padding DMA testbench,
 * random ready and valid delays, AW and W beat log
 */
`default_nettype none

module tb_axi_mem #(
    parameter int          WORDS     = 4096,
    parameter int          LOG_DEPTH = 128,
    parameter logic [31:0] SEED      = 32'h0000_0001
) (
    input  logic              clk,
    input  logic              rst_n,
    input  pad_pkg::rd_req_t  ar_i,
    input  logic              arvalid_i,
    output logic              arready_o = 1'b0,
    output pad_pkg::data_t    rdata_o = '0,
    output logic              rlast_o = 1'b0,
    output logic              rvalid_o = 1'b0,
    input  logic              rready_i,
    input  pad_pkg::wr_req_t  aw_i,
    input  logic              awvalid_i,
    output logic              awready_o = 1'b0,
    input  pad_pkg::wr_beat_t w_i,
    input  logic              wvalid_i,
    output logic              wready_o = 1'b0,
    output logic              bvalid_o = 1'b0,
    input  logic              bready_i
);
    timeunit 1ns;
    timeprecision 100ps;

    pad_pkg::data_t   words [WORDS];
    pad_pkg::wr_req_t aw_log [LOG_DEPTH];   // Accepted AW requests in order
    int               beat_log [LOG_DEPTH]; // W beats up to and including wlast
    int               aw_count;
    logic [31:0]      lfsr_q = SEED;
    logic [31:0]      rd_ptr;
    int               rd_left;
    logic [31:0]      wr_ptr;
    int               wr_beats;
    logic             wr_busy;
    logic             b_pend;
    logic             r_hold;
    logic             b_hold;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic random_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            rd_left  = 0;
            wr_busy  = 1'b0;
            b_pend   = 1'b0;
            aw_count = 0;
            r_hold   = 1'b0;
            b_hold   = 1'b0;
        end else begin
            r_hold = rvalid_o & ~rready_i;  // Valid stays up until taken
            b_hold = bvalid_o & ~bready_i;
            if (arvalid_i && arready_o) begin
                rd_ptr  = ar_i.addr;
                rd_left = int'(ar_i.len) + 1;
            end
            if (rvalid_o && rready_i) begin
                rd_ptr  = rd_ptr + 32'd4;
                rd_left = rd_left - 1;
            end
            if (awvalid_i && awready_o) begin
                wr_ptr   = aw_i.addr;
                wr_beats = 0;
                wr_busy  = 1'b1;
                if (aw_count < LOG_DEPTH) aw_log[aw_count] = aw_i;
            end
            if (wvalid_i && wready_o && wr_busy) begin
                words[wr_ptr >> 2] = w_i.data;
                wr_ptr   = wr_ptr + 32'd4;
                wr_beats = wr_beats + 1;
                if (w_i.last) begin
                    if (aw_count < LOG_DEPTH) beat_log[aw_count] = wr_beats;
                    aw_count = aw_count + 1;
                    wr_busy  = 1'b0;
                    b_pend   = 1'b1;
                end
            end
            if (bvalid_o && bready_i) b_pend = 1'b0;
        end

        #1;
        arready_o = random_bit();
        awready_o = random_bit();
        wready_o  = random_bit();
        if (!r_hold) begin
            rvalid_o = (rd_left > 0) && random_bit();
            rdata_o  = words[rd_ptr >> 2];
            rlast_o  = (rd_left == 1);
        end
        if (!b_hold) bvalid_o = b_pend && random_bit();
    end

endmodule

`default_nettype wire

// File: tests/tb_pad_dma.sv
/*
 * Mirror-padding DMA testbench with random matrices,
 * mirror-rule output model, AW burst and guard word checks
 */
`default_nettype none

module tb_pad_dma;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED    = 32'hba2d_94d3;
    localparam int          WORDS   = 4096;
    localparam int          TIMEOUT = 20000;  // Cycles per run

    logic              clk;
    logic              rst_n;
    logic [31:0]       src_addr;
    logic [31:0]       dst_addr;
    pad_pkg::dim_t     mat_width;
    logic              start;
    logic              done;
    pad_pkg::rd_req_t  ar;
    logic              arvalid;
    logic              arready;
    pad_pkg::data_t    rdata;
    logic              rlast;
    logic              rvalid;
    logic              rready;
    pad_pkg::wr_req_t  aw;
    logic              awvalid;
    logic              awready;
    pad_pkg::wr_beat_t w;
    logic              wvalid;
    logic              wready;
    logic              bvalid;
    logic              bready;

    logic [31:0]    lfsr_q = SEED;
    pad_pkg::data_t src_data [256];   // Source matrix up to 16x16
    int             data_errors = 0;
    int             len_errors = 0;
    int             addr_errors = 0;
    int             other_errors = 0;
    logic           run_ok;

    pad_dma_top #(.ADDR_W(32)) uut (
        .clk(clk), .rst_n(rst_n),
        .src_addr_i(src_addr), .dst_addr_i(dst_addr),
        .mat_width_i(mat_width), .start_i(start), .done_o(done),
        .ar_o(ar), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rlast_i(rlast), .rvalid_i(rvalid), .rready_o(rready),
        .aw_o(aw), .awvalid_o(awvalid), .awready_i(awready),
        .w_o(w), .wvalid_o(wvalid), .wready_i(wready),
        .bvalid_i(bvalid), .bready_o(bready)
    );

    tb_axi_mem #(.WORDS(WORDS), .SEED(SEED)) u_mem (
        .clk(clk), .rst_n(rst_n),
        .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rlast_o(rlast), .rvalid_o(rvalid), .rready_i(rready),
        .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
        .w_i(w), .wvalid_i(wvalid), .wready_o(wready),
        .bvalid_o(bvalid), .bready_i(bready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic next_random_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic pad_pkg::data_t random_word();
        pad_pkg::data_t v;
        for (int i = 0; i < 32; i++) v = {v[30:0], next_random_bit()};
        return v;
    endfunction

    // Mirror without repeating the edge
    function automatic int reflect(input int k, input int n);
        if (k < 0) return 1;
        if (k >= n) return n - 2;
        return k;
    endfunction

    function automatic pad_pkg::data_t guard_word(input int a);
        return 32'hc0de_0000 ^ 32'(a);
    endfunction

    task automatic check_word(input string name, input pad_pkg::data_t exp,
                              input pad_pkg::data_t act);
        if (act !== exp) begin
            data_errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input pad_pkg::len_t exp,
                             input pad_pkg::len_t act);
        if (act !== exp) begin
            len_errors++;
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            addr_errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("Errors: data %0d, length %0d, address %0d, other %0d",
                 data_errors, len_errors, addr_errors, other_errors);
        if (data_errors + len_errors + addr_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic wait_done(input int n, output logic ok);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = (done === 1'b1);
        if (!ok) begin
            other_errors++;
            $display("Timeout: done_o did not rise during the run with N=%0d", n);
        end
    endtask

    task automatic load_memory(input int n, input int src_w, input int dst_w);
        for (int a = 0; a < WORDS; a++) u_mem.words[a] = guard_word(a);
        for (int i = 0; i < n * n; i++) begin
            src_data[i]            = random_word();
            u_mem.words[src_w + i] = src_data[i];
        end
        u_mem.aw_count = 0;
        src_addr  = 32'(src_w * 4);
        dst_addr  = 32'(dst_w * 4);
        mat_width = pad_pkg::dim_t'(n);
    endtask

    task automatic verify_output(input int n, input int src_w, input int dst_w);
        pad_pkg::data_t exp;
        int             out_words;
        out_words = (n + 2) * (n + 2);
        for (int r = 0; r < n + 2; r++) begin
            for (int c = 0; c < n + 2; c++) begin
                exp = src_data[reflect(r - 1, n) * n + reflect(c - 1, n)];
                check_word($sformatf("out[%0d][%0d] N=%0d", r, c, n), exp,
                           u_mem.words[dst_w + r * (n + 2) + c]);
            end
        end
        // Everything outside the output region keeps its old value
        for (int a = 0; a < WORDS; a++) begin
            if (a >= src_w && a < src_w + n * n) begin
                check_word($sformatf("source word %0d N=%0d", a, n),
                           src_data[a - src_w], u_mem.words[a]);
            end else if (a < dst_w || a >= dst_w + out_words) begin
                check_word($sformatf("guard word %0d N=%0d", a, n),
                           guard_word(a), u_mem.words[a]);
            end
        end
    endtask

    task automatic verify_bursts(input int n, input int dst_w);
        pad_pkg::wr_req_t req;
        string            name;
        int               k;
        int               tiles;
        int               top;
        int               bottom;
        int               left;
        int               right;
        int               sr;
        int               sc;
        int               rows;
        int               cols;
        k     = 0;
        tiles = n / 4;
        for (int by = 0; by < tiles; by++) begin
            for (int bx = 0; bx < tiles; bx++) begin
                top    = (by == 0);
                bottom = (by == tiles - 1);
                left   = (bx == 0);
                right  = (bx == tiles - 1);
                sr     = top ? 0 : 4 * by + 1;
                sc     = left ? 0 : 4 * bx + 1;
                rows   = 4 + top + bottom;
                cols   = 4 + left + right;
                for (int i = 0; i < rows; i++) begin
                    if (k < u_mem.aw_count) begin
                        req  = u_mem.aw_log[k];
                        name = $sformatf("AW %0d tile (%0d,%0d) N=%0d", k, by, bx, n);
                        check_addr(name, 32'((dst_w + (sr + i) * (n + 2) + sc) * 4),
                                   req.addr);
                        check_len(name, pad_pkg::len_t'(cols - 1), req.len);
                        check_len({name, " wlast"}, pad_pkg::len_t'(cols - 1),
                                  pad_pkg::len_t'(u_mem.beat_log[k] - 1));
                    end
                    k++;
                end
            end
        end
        if (k != u_mem.aw_count) begin
            other_errors++;
            $display("Wrong number of write bursts for N=%0d: %0d seen, %0d expected",
                     n, u_mem.aw_count, k);
        end
    endtask

    // Called right after done_o is seen high so runs follow back to back
    task automatic run_matrix(input int n, input int src_w, input int dst_w,
                              output logic ok);
        load_memory(n, src_w, dst_w);
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (done !== 1'b0) begin
            other_errors++;
            $display("done_o did not drop after start for N=%0d", n);
        end
        wait_done(n, ok);
        if (ok) begin
            verify_output(n, src_w, dst_w);
            verify_bursts(n, dst_w);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        src_addr  = '0;
        dst_addr  = '0;
        mat_width = '0;
        repeat (16) @(posedge clk);
        #1;
        if (done !== 1'b1 || arvalid !== 1'b0 || rready !== 1'b0 || awvalid !== 1'b0
            || wvalid !== 1'b0 || bready !== 1'b0) begin
            other_errors++;
            $display("DUT not idle in reset");
            $display("  done %b arvalid %b rready %b awvalid %b wvalid %b bready %b",
                     done, arvalid, rready, awvalid, wvalid, bready);
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        run_ok = 1'b1;
        for (int k = 0; k < 4 && run_ok; k++) begin
            run_matrix(4 * (k + 1), 16 + 8 * k, 1024 + 24 * k, run_ok);  // N = 4..16
        end
        if (run_ok) begin
            run_matrix(12, 40, 1100, run_ok);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: verilog.f
src/pad_pkg.sv
src/pad_tile_walker.sv
src/pad_addr_gen.sv
src/pad_tile_buffer.sv
src/pad_dma_ctrl.sv
src/pad_dma_top.sv
tests/tb_axi_mem.sv
tests/tb_pad_dma.sv
